//--- source/dccm_pkg.sv
//================================================
// widths, register map and types for the DCCM banks
// the check code is stored as given and never computed here
//================================================
`default_nettype none

package dccm_pkg;

        localparam int DCCM_DATA_WIDTH  = 32;
        localparam int DCCM_ECC_WIDTH   = 7;
        localparam int DCCM_FDATA_WIDTH = DCCM_ECC_WIDTH + DCCM_DATA_WIDTH;
        localparam int DCCM_BYTE_WIDTH  = 4;    // bytes per bank word
        localparam int FLIP_POS_WIDTH   = 6;
        localparam int AXIL_ADDR_WIDTH  = 4;
        localparam int AXIL_DATA_WIDTH  = 32;

        typedef logic [DCCM_DATA_WIDTH-1:0]  dccm_data_t;
        typedef logic [DCCM_ECC_WIDTH-1:0]   dccm_ecc_t;
        typedef logic [DCCM_FDATA_WIDTH-1:0] dccm_fdata_t;    // ecc in the upper bits
        typedef logic [FLIP_POS_WIDTH-1:0]   flip_pos_t;
        typedef logic [AXIL_ADDR_WIDTH-1:0]  axil_addr_t;
        typedef logic [AXIL_DATA_WIDTH-1:0]  axil_data_t;
        typedef logic [1:0]                  axil_resp_t;

        // register byte offsets
        localparam axil_addr_t REG_CTRL      = 4'h0;
        localparam axil_addr_t REG_FLIP_POS  = 4'h4;
        localparam axil_addr_t REG_BANK_MASK = 4'h8;
        localparam axil_addr_t REG_INJ_COUNT = 4'hC;    // read only, write clears

        localparam int CTRL_SINGLE_BIT = 0;
        localparam int CTRL_DOUBLE_BIT = 1;
        localparam int POS0_LSB        = 0;    // field offsets in REG_FLIP_POS
        localparam int POS1_LSB        = 8;

        localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- source/dccm_inject_regs.sv
//================================================
// AXI4-Lite register block for error injection
// no strobes, whole words only; up to 32 banks in the mask
//================================================
`timescale 1ns/1ps
`default_nettype none

module dccm_inject_regs #(
        parameter int DCCM_NUM_BANKS = 4
) (
        input  logic                      clk,
        input  logic                      rst_n,
        // write address, data and response
        input  logic                      awvalid,
        output logic                      awready,
        input  dccm_pkg::axil_addr_t      awaddr,
        input  logic                      wvalid,
        output logic                      wready,
        input  dccm_pkg::axil_data_t      wdata,
        output logic                      bvalid,
        input  logic                      bready,
        output dccm_pkg::axil_resp_t      bresp,
        // read address and data
        input  logic                      arvalid,
        output logic                      arready,
        input  dccm_pkg::axil_addr_t      araddr,
        output logic                      rvalid,
        input  logic                      rready,
        output dccm_pkg::axil_data_t      rdata,
        output dccm_pkg::axil_resp_t      rresp,
        // injection control
        output logic                      single_en,
        output logic                      double_en,
        output dccm_pkg::flip_pos_t       pos0,
        output dccm_pkg::flip_pos_t       pos1,
        output logic [DCCM_NUM_BANKS-1:0] bank_mask,
        output logic                      count_clear,
        input  dccm_pkg::axil_data_t      inj_count
);

        import dccm_pkg::*;

        logic       wr_accept;
        logic       rd_accept;
        axil_data_t rd_word;

        // address and data are taken together, one response outstanding
        assign wr_accept = awvalid & wvalid & ~bvalid;
        assign rd_accept = arvalid & ~rvalid;

        assign awready = wr_accept;
        assign wready  = wr_accept;
        assign arready = rd_accept;
        assign bresp   = AXIL_RESP_OKAY;
        assign rresp   = AXIL_RESP_OKAY;

        assign count_clear = wr_accept & (awaddr == REG_INJ_COUNT);    // one cycle pulse

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        single_en <= 1'b0;
                        double_en <= 1'b0;
                        pos0      <= '0;
                        pos1      <= '0;
                        bank_mask <= '0;
                end else if (wr_accept) begin
                        case (awaddr)
                                REG_CTRL: begin
                                        single_en <= wdata[CTRL_SINGLE_BIT];
                                        double_en <= wdata[CTRL_DOUBLE_BIT];
                                end
                                REG_FLIP_POS: begin
                                        pos0 <= wdata[POS0_LSB +: FLIP_POS_WIDTH];
                                        pos1 <= wdata[POS1_LSB +: FLIP_POS_WIDTH];
                                end
                                REG_BANK_MASK: begin
                                        bank_mask <= wdata[DCCM_NUM_BANKS-1:0];
                                end
                                default: begin
                                        // count clear is the pulse above
                                end
                        endcase
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        bvalid <= 1'b0;
                end else if (wr_accept) begin
                        bvalid <= 1'b1;
                end else if (bready) begin
                        bvalid <= 1'b0;
                end
        end

        // read mux, unmapped offsets give zero
        always_comb begin
                rd_word = '0;
                case (araddr)
                        REG_CTRL: begin
                                rd_word[CTRL_SINGLE_BIT] = single_en;
                                rd_word[CTRL_DOUBLE_BIT] = double_en;
                        end
                        REG_FLIP_POS: begin
                                rd_word[POS0_LSB +: FLIP_POS_WIDTH] = pos0;
                                rd_word[POS1_LSB +: FLIP_POS_WIDTH] = pos1;
                        end
                        REG_BANK_MASK: begin
                                rd_word[DCCM_NUM_BANKS-1:0] = bank_mask;
                        end
                        REG_INJ_COUNT: begin
                                rd_word = inj_count;
                        end
                        default: begin
                                rd_word = '0;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rvalid <= 1'b0;
                        rdata  <= '0;
                end else if (rd_accept) begin
                        rvalid <= 1'b1;
                        rdata  <= rd_word;    // held until rready
                end else if (rready) begin
                        rvalid <= 1'b0;
                end
        end

endmodule

`default_nettype wire

//--- source/dccm_bitflip_inject.sv
//================================================
// flips register-chosen bits of bank write words
// positions 39 and up flip nothing but the write still counts
//================================================
`timescale 1ns/1ps
`default_nettype none

module dccm_bitflip_inject #(
        parameter int DCCM_NUM_BANKS = 4
) (
        input  logic                                        clk,
        input  logic                                        rst_n,
        input  logic [DCCM_NUM_BANKS-1:0]                   clken,
        input  logic [DCCM_NUM_BANKS-1:0]                   wren,
        input  dccm_pkg::dccm_fdata_t [DCCM_NUM_BANKS-1:0]  wr_fdata,
        input  logic                                        single_en,
        input  logic                                        double_en,
        input  dccm_pkg::flip_pos_t                         pos0,
        input  dccm_pkg::flip_pos_t                         pos1,
        input  logic [DCCM_NUM_BANKS-1:0]                   bank_mask,
        input  logic                                        count_clear,
        output dccm_pkg::dccm_fdata_t [DCCM_NUM_BANKS-1:0]  ram_wdata,
        output dccm_pkg::axil_data_t                        inj_count
);

        import dccm_pkg::*;

        localparam int CNT_INC_W = $clog2(DCCM_NUM_BANKS + 1);

        dccm_fdata_t               mask_pos0;
        dccm_fdata_t               mask_pos1;
        dccm_fdata_t               flip_mask;
        logic [DCCM_NUM_BANKS-1:0] flip_act;
        logic [CNT_INC_W-1:0]      flip_cnt;
        logic [AXIL_DATA_WIDTH:0]  cnt_sum;

        function automatic dccm_fdata_t pos_onehot(input flip_pos_t pos);
                dccm_fdata_t oh;
                oh = '0;
                if (pos < DCCM_FDATA_WIDTH) begin    // out of range leaves the word alone
                        oh[pos] = 1'b1;
                end
                return oh;
        endfunction

        assign mask_pos0 = pos_onehot(pos0);
        assign mask_pos1 = pos_onehot(pos1);

        // double mode wins; equal positions cancel out
        always_comb begin
                if (double_en) begin
                        flip_mask = mask_pos0 ^ mask_pos1;
                end else if (single_en) begin
                        flip_mask = mask_pos0;
                end else begin
                        flip_mask = '0;
                end
        end

        assign flip_act = clken & wren & bank_mask & {DCCM_NUM_BANKS{single_en | double_en}};

        for (genvar i = 0; i < DCCM_NUM_BANKS; i++) begin : g_flip
                assign ram_wdata[i] = wr_fdata[i] ^ ({DCCM_FDATA_WIDTH{flip_act[i]}} & flip_mask);
        end

        // banks hit in this cycle
        always_comb begin
                flip_cnt = '0;
                for (int b = 0; b < DCCM_NUM_BANKS; b++) begin
                        flip_cnt = flip_cnt + CNT_INC_W'(flip_act[b]);
                end
        end

        assign cnt_sum = {1'b0, inj_count} + (AXIL_DATA_WIDTH + 1)'(flip_cnt);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        inj_count <= '0;
                end else if (count_clear) begin
                        inj_count <= '0;    // clear beats increment
                end else if (cnt_sum[AXIL_DATA_WIDTH]) begin
                        inj_count <= '1;    // saturate
                end else begin
                        inj_count <= cnt_sum[AXIL_DATA_WIDTH-1:0];
                end
        end

endmodule

`default_nettype wire

//--- source/dccm_bank_ram.sv
//================================================
// behavioural single-port bank, one clock read latency
// q holds its value between reads and is X until the first
//================================================
`timescale 1ns/1ps
`default_nettype none

module dccm_bank_ram #(
        parameter  int DEPTH  = 256,
        localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
        input  logic                  clk,
        input  logic                  me,
        input  logic                  we,
        input  logic [ADDR_W-1:0]     adr,
        input  dccm_pkg::dccm_fdata_t d,
        output dccm_pkg::dccm_fdata_t q
);

        import dccm_pkg::*;

        dccm_fdata_t mem [DEPTH];

        always_ff @(posedge clk) begin
                if (me && we) begin
                        mem[adr] <= d;
                end
        end

        // read port, q left alone on writes
        always_ff @(posedge clk) begin
                if (me && !we) begin
                        q <= mem[adr];
                end
        end

endmodule

`default_nettype wire

//--- source/dccm_sram_export.sv
//================================================
// DCCM banks with register-driven write bit-flip injection
// banks are 4 bytes wide; at most 32 banks
//================================================
`timescale 1ns/1ps
`default_nettype none

module dccm_sram_export #(
        parameter  int DCCM_NUM_BANKS   = 4,
        parameter  int DCCM_SIZE_KB     = 4,
        localparam int DCCM_INDEX_DEPTH =
                (DCCM_SIZE_KB * 1024) / (dccm_pkg::DCCM_BYTE_WIDTH * DCCM_NUM_BANKS),
        localparam int DCCM_ADDR_WIDTH  =
                (DCCM_INDEX_DEPTH > 1) ? $clog2(DCCM_INDEX_DEPTH) : 1
) (
        input  logic                                         clk,
        input  logic                                         rst_n,
        // core side, one lane per bank
        input  logic [DCCM_NUM_BANKS-1:0]                    clken,
        input  logic [DCCM_NUM_BANKS-1:0]                    wren,
        input  logic [DCCM_NUM_BANKS-1:0][DCCM_ADDR_WIDTH-1:0] addr,
        input  dccm_pkg::dccm_data_t [DCCM_NUM_BANKS-1:0]    wr_data,
        input  dccm_pkg::dccm_ecc_t [DCCM_NUM_BANKS-1:0]     wr_ecc,
        output dccm_pkg::dccm_data_t [DCCM_NUM_BANKS-1:0]    dout,
        output dccm_pkg::dccm_ecc_t [DCCM_NUM_BANKS-1:0]     ecc,
        // AXI4-Lite injection registers
        input  logic                                         awvalid,
        output logic                                         awready,
        input  dccm_pkg::axil_addr_t                         awaddr,
        input  logic                                         wvalid,
        output logic                                         wready,
        input  dccm_pkg::axil_data_t                         wdata,
        output logic                                         bvalid,
        input  logic                                         bready,
        output dccm_pkg::axil_resp_t                         bresp,
        input  logic                                         arvalid,
        output logic                                         arready,
        input  dccm_pkg::axil_addr_t                         araddr,
        output logic                                         rvalid,
        input  logic                                         rready,
        output dccm_pkg::axil_data_t                         rdata,
        output dccm_pkg::axil_resp_t                         rresp
);

        import dccm_pkg::*;

        dccm_fdata_t [DCCM_NUM_BANKS-1:0] wr_fdata;
        dccm_fdata_t [DCCM_NUM_BANKS-1:0] ram_wdata;
        dccm_fdata_t [DCCM_NUM_BANKS-1:0] ram_q;
        logic                             single_en;
        logic                             double_en;
        flip_pos_t                        pos0;
        flip_pos_t                        pos1;
        logic [DCCM_NUM_BANKS-1:0]        bank_mask;
        logic                             count_clear;
        axil_data_t                       inj_count;

        dccm_inject_regs #(
                .DCCM_NUM_BANKS (DCCM_NUM_BANKS)
        ) i_inject_regs (
                .clk         (clk),
                .rst_n       (rst_n),
                .awvalid     (awvalid),
                .awready     (awready),
                .awaddr      (awaddr),
                .wvalid      (wvalid),
                .wready      (wready),
                .wdata       (wdata),
                .bvalid      (bvalid),
                .bready      (bready),
                .bresp       (bresp),
                .arvalid     (arvalid),
                .arready     (arready),
                .araddr      (araddr),
                .rvalid      (rvalid),
                .rready      (rready),
                .rdata       (rdata),
                .rresp       (rresp),
                .single_en   (single_en),
                .double_en   (double_en),
                .pos0        (pos0),
                .pos1        (pos1),
                .bank_mask   (bank_mask),
                .count_clear (count_clear),
                .inj_count   (inj_count)
        );

        dccm_bitflip_inject #(
                .DCCM_NUM_BANKS (DCCM_NUM_BANKS)
        ) i_bitflip_inject (
                .clk         (clk),
                .rst_n       (rst_n),
                .clken       (clken),
                .wren        (wren),
                .wr_fdata    (wr_fdata),
                .single_en   (single_en),
                .double_en   (double_en),
                .pos0        (pos0),
                .pos1        (pos1),
                .bank_mask   (bank_mask),
                .count_clear (count_clear),
                .ram_wdata   (ram_wdata),
                .inj_count   (inj_count)
        );

        for (genvar i = 0; i < DCCM_NUM_BANKS; i++) begin : g_bank
                assign wr_fdata[i] = {wr_ecc[i], wr_data[i]};    // ecc on top
                assign dout[i]     = ram_q[i][DCCM_DATA_WIDTH-1:0];
                assign ecc[i]      = ram_q[i][DCCM_FDATA_WIDTH-1:DCCM_DATA_WIDTH];

                dccm_bank_ram #(
                        .DEPTH (DCCM_INDEX_DEPTH)
                ) i_bank_ram (
                        .clk (clk),
                        .me  (clken[i]),
                        .we  (wren[i]),
                        .adr (addr[i]),
                        .d   (ram_wdata[i]),
                        .q   (ram_q[i])
                );
        end

endmodule

`default_nettype wire

//--- tests/dccm_sram_export_assertions.sv
//================================================
// AXI4-Lite response rules, bound into the DCCM top level
// rdata must stay stable while rvalid waits for rready
//================================================
`timescale 1ns/1ps
`default_nettype none

module dccm_sram_export_assertions (
        input logic                 clk,
        input logic                 rst_n,
        input logic                 bvalid,
        input logic                 bready,
        input dccm_pkg::axil_resp_t bresp,
        input logic                 rvalid,
        input logic                 rready,
        input dccm_pkg::axil_data_t rdata,
        input dccm_pkg::axil_resp_t rresp
);

        import dccm_pkg::*;

        int fail_count = 0;

        a_reset_idle: assert property (@(posedge clk) !rst_n |-> !bvalid && !rvalid)
                else begin
                        fail_count++;
                        $error("bvalid or rvalid high while in reset");
                end

        a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
                        bvalid && !bready |=> bvalid)
                else begin
                        fail_count++;
                        $error("bvalid dropped before bready");
                end

        a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
                        rvalid && !rready |=> rvalid && $stable(rdata))
                else begin
                        fail_count++;
                        $error("rvalid or rdata changed before rready");
                end

        a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
                        bvalid |-> bresp == AXIL_RESP_OKAY)
                else begin
                        fail_count++;
                        $error("bresp is not OKAY");
                end

        a_rresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
                        rvalid |-> rresp == AXIL_RESP_OKAY)
                else begin
                        fail_count++;
                        $error("rresp is not OKAY");
                end

endmodule

bind dccm_sram_export dccm_sram_export_assertions i_assertions (.*);

`default_nettype wire

//--- tests/tb_dccm_sram_export.sv
//================================================
// testbench for the DCCM banks and injection registers
// assumes the default 4 banks of 256 words
//================================================
`timescale 1ns/1ps
`default_nettype none

module tb_dccm_sram_export;

        localparam int NB              = 4;
        localparam int AW              = 8;
        localparam int NUM_TESTS       = 5;
        localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

        logic                  clk = 1'b0;
        logic                  rst_n;
        logic [NB-1:0]         clken, wren;
        logic [NB-1:0][AW-1:0] addr;
        logic [NB-1:0][31:0]   wr_data, dout;
        logic [NB-1:0][6:0]    wr_ecc, ecc;
        logic                  awvalid, awready, wvalid, wready, bvalid, bready;
        logic                  arvalid, arready, rvalid, rready;
        logic [3:0]            awaddr, araddr;
        logic [31:0]           wdata, rdata, rd;
        logic [1:0]            bresp, rresp;

        logic                  sh_single, sh_double;    // register state as written
        logic [5:0]            sh_pos0, sh_pos1;
        logic [NB-1:0]         sh_mask;
        logic [38:0]           model [NB][256];    // expected bank contents
        int                    exp_count, errors, test_errors, tests_run, tests_failed;
        integer                seed = 32'h4eec_33db;

        dccm_sram_export #(.DCCM_NUM_BANKS(NB), .DCCM_SIZE_KB(4)) i_dccm_sram_export (.*);

        always #20 clk = ~clk;

        task automatic check_value(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
                assert (actual === expected) else begin
                        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
                        errors++;
                        test_errors++;
                end
        endtask

        // word as it should land in bank b
        function automatic logic [38:0] inject_expect(input logic [38:0] w, input int b);
                logic [63:0] flips;
                flips = '0;
                if (sh_mask[b] && sh_double) begin
                        flips = (64'd1 << sh_pos0) ^ (64'd1 << sh_pos1);    // equal ones cancel
                end else if (sh_mask[b] && sh_single) begin
                        flips = 64'd1 << sh_pos0;
                end
                return w ^ flips[38:0];    // positions 39 and up fall off
        endfunction

        task automatic write_req(input logic [3:0] a, input logic [31:0] d);
                @(posedge clk);
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
                awaddr  <= a;
                wdata   <= d;
                do @(negedge clk); while (!(awready && wready));
                @(posedge clk);
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
        endtask

        task automatic write_resp();
                do @(negedge clk); while (!bvalid);
        endtask

        task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
                write_req(a, d);
                write_resp();
                case (a)
                        4'h0: {sh_double, sh_single} = d[1:0];
                        4'h4: {sh_pos1, sh_pos0} = {d[13:8], d[5:0]};
                        4'h8: sh_mask = d[NB-1:0];
                        default: exp_count = 0;    // count clears on write
                endcase
        endtask

        task automatic reg_read(input logic [3:0] a, output logic [31:0] d);
                @(posedge clk);
                arvalid <= 1'b1;
                araddr  <= a;
                do @(negedge clk); while (!arready);
                @(posedge clk);
                arvalid <= 1'b0;
                do @(negedge clk); while (!rvalid);
                d = rdata;
        endtask

        task automatic bank_write_all(input logic [AW-1:0] a);
                logic [38:0] w;
                @(posedge clk);
                for (int b = 0; b < NB; b++) begin
                        w = {7'($random(seed)), 32'($random(seed))};
                        addr[b]    <= a;
                        wr_data[b] <= w[31:0];
                        wr_ecc[b]  <= w[38:32];
                        model[b][a] = inject_expect(w, b);
                        exp_count += int'(sh_mask[b] & (sh_single | sh_double));
                end
                clken <= '1;
                wren  <= '1;
                @(posedge clk);
                clken <= '0;
                wren  <= '0;
        endtask

        task automatic bank_read_check(input string name, input logic [AW-1:0] a);
                @(posedge clk);
                addr  <= {NB{a}};
                clken <= '1;
                wren  <= '0;
                @(posedge clk);
                clken <= '0;
                @(negedge clk);    // dout and ecc one cycle after the read
                for (int b = 0; b < NB; b++) begin
                        check_value(name, 64'(model[b][a]), 64'({ecc[b], dout[b]}));
                end
        endtask

        task automatic flip_case(input string name, input logic [5:0] p0, input logic [5:0] p1,
                                 input logic [NB-1:0] m, input logic [AW-1:0] a);
                reg_write(4'h4, {18'd0, p1, 2'd0, p0});
                reg_write(4'h8, 32'(m));
                bank_write_all(a);
                bank_read_check(name, a);
        endtask

        task automatic end_test(input string name);
                tests_run++;
                if (test_errors != 0) begin
                        tests_failed++;
                end
                $display("test %s done, %0d errors", name, test_errors);
                test_errors = 0;
        endtask

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
                $display("FAIL: see errors above");
                $finish;
        end

        initial begin
                {sh_single, sh_double, sh_pos0, sh_pos1, sh_mask} = '0;
                rst_n   <= 1'b0;
                clken   <= '0;
                wren    <= '0;
                addr    <= '0;
                wr_data <= '0;
                wr_ecc  <= '0;
                awvalid <= 1'b0;
                awaddr  <= '0;
                wvalid  <= 1'b0;
                wdata   <= '0;
                bready  <= 1'b1;
                arvalid <= 1'b0;
                araddr  <= '0;
                rready  <= 1'b1;
                repeat (16) @(posedge clk);
                rst_n <= 1'b1;

                for (int i = 0; i < 4; i++) begin
                        bank_write_all(AW'(i * 37));
                end
                for (int i = 0; i < 4; i++) begin
                        bank_read_check("plain_storage", AW'(i * 37));
                end
                end_test("plain_storage");

                reg_write(4'h0, 32'h1);
                flip_case("single_inject", 6'd5, 6'd0, 4'b0101, 8'h10);
                flip_case("single_inject", 6'd37, 6'd0, 4'b1010, 8'h11);
                end_test("single_inject");

                reg_write(4'h0, 32'h2);
                flip_case("double_inject", 6'd3, 6'd36, 4'b1111, 8'h20);
                flip_case("double_inject", 6'd10, 6'd10, 4'b0110, 8'h21);
                flip_case("double_inject", 6'd2, 6'd45, 4'b1001, 8'h22);
                flip_case("double_inject", 6'd50, 6'd63, 4'b1111, 8'h23);
                end_test("double_inject");

                reg_write(4'hC, 32'h0);
                reg_write(4'h0, 32'h1);
                flip_case("inject_count", 6'd7, 6'd20, 4'b1011, 8'h30);
                bank_write_all(8'h31);
                bank_write_all(8'h32);
                reg_write(4'h0, 32'h0);
                bank_write_all(8'h33);    // count stays with injection off
                reg_read(4'hC, rd);
                check_value("inject_count", 64'(exp_count), 64'(rd));
                reg_write(4'hC, 32'h0);
                reg_read(4'hC, rd);
                check_value("inject_count", 64'h0, 64'(rd));
                end_test("inject_count");

                reg_write(4'h0, 32'h3);
                reg_read(4'h0, rd);
                check_value("register_access", 64'h3, 64'(rd));
                reg_write(4'h4, 32'h0000_2a15);
                reg_read(4'h4, rd);
                check_value("register_access", 64'h2a15, 64'(rd));
                reg_write(4'h8, 32'h9);
                reg_read(4'h8, rd);
                check_value("register_access", 64'h9, 64'(rd));
                @(posedge clk);
                bready <= 1'b0;    // hold the write response
                write_req(4'h8, 32'h5);
                @(posedge clk);
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
                awaddr  <= 4'h8;
                wdata   <= 32'h6;
                repeat (4) begin
                        @(negedge clk);
                        check_value("register_access", 64'h1, 64'(bvalid));
                        check_value("register_access", 64'h0, 64'(awready));
                        check_value("register_access", 64'h0, 64'(wready));
                end
                @(posedge clk);
                bready <= 1'b1;
                do @(negedge clk); while (!(awready && wready));
                @(posedge clk);
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
                write_resp();
                reg_read(4'h8, rd);
                check_value("register_access", 64'h6, 64'(rd));
                @(posedge clk);
                rready  <= 1'b0;    // hold the read response
                arvalid <= 1'b1;
                araddr  <= 4'h4;
                do @(negedge clk); while (!arready);
                @(posedge clk);
                araddr <= 4'h0;    // next read waits behind the held one
                repeat (4) begin
                        @(negedge clk);
                        check_value("register_access", 64'h1, 64'(rvalid));
                        check_value("register_access", 64'h0, 64'(arready));
                        check_value("register_access", 64'h2a15, 64'(rdata));
                end
                @(posedge clk);
                rready <= 1'b1;
                do @(negedge clk); while (!arready);
                @(posedge clk);
                arvalid <= 1'b0;
                do @(negedge clk); while (!rvalid);
                check_value("register_access", 64'h3, 64'(rdata));
                end_test("register_access");

                $display("tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
                         tests_run, tests_failed, errors,
                         i_dccm_sram_export.i_assertions.fail_count);
                if (errors == 0 && i_dccm_sram_export.i_assertions.fail_count == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- dccm_sram_export.f
source/dccm_pkg.sv
source/dccm_inject_regs.sv
source/dccm_bitflip_inject.sv
source/dccm_bank_ram.sv
source/dccm_sram_export.sv
tests/dccm_sram_export_assertions.sv
tests/tb_dccm_sram_export.sv

//--- Makefile
# Verilator build and run of the DCCM testbench
TOP = tb_dccm_sram_export

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f dccm_sram_export.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
